/* mem_branch.f */
common/rv_isa_pkg.sv
common/mb_stage_pkg.sv
mem_access/dmem_ram.sv
mem_access/mem_access.sv
src/branch_resolve.sv
src/trap_arbiter.sv
src/mem_branch.sv
dv/mem_branch_checker.sv
dv/mem_branch_tb.sv

/* run.sh */
#!/bin/bash
# build and run the testbench, exit status follows the simulation result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module mem_branch_tb \
   -f mem_branch.f \
   && ./obj_dir/Vmem_branch_tb \
   || exit 1

exit 0

/* dv/mem_branch_tb.sv */
`timescale 1ns/1ps

module mem_branch_tb
   import rv_isa_pkg::*;
   import mb_stage_pkg::*;
();

   // reset, pool init, loads and stores, misalign, jumps, traps, interrupt, flush, tail.
   localparam int TEST_CYCLES = 8 + 8 + 3*24 + 4 + 16 + 6 + 4 + 4 + 8;
   localparam int CLK_NS      = 40;

   logic       clk;
   logic       rst;
   logic       pipe_flush;
   logic       external_int;
   ex_mb_t     ex;
   redirect_t  redirect;
   logic [31:0] dmem_addr;
   load_t      load;

   int          seed = 32'h1c18_cf24;
   logic [31:0] shadow [DMEM_WORDS];
   logic [31:0] addr_pool [8];
   logic        pend_model;
   load_t       exp_load;
   logic        exp_data_known;

   mem_branch dut0 (
      .clk          (clk),
      .rst          (rst),
      .pipe_flush   (pipe_flush),
      .external_int (external_int),
      .ex           (ex),
      .redirect     (redirect),
      .dmem_addr    (dmem_addr),
      .load         (load)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS/2) clk = ~clk;
   end

   initial begin
      #(CLK_NS * (TEST_CYCLES + 20));
      $display("Simulation timed out before the tests finished.");
      $display("Test FAILED");
      $fatal(1);
   end

   function automatic logic is_misaligned(input width_e w, input logic [1:0] off);
      return (w == width_half && off == 2'b11) || (w == width_word && off != 2'b00);
   endfunction

   // expected redirect from the stage rules.
   function automatic redirect_t ref_redirect(input ex_mb_t e, input logic pend,
                                              input logic flush);
      redirect_t   r;
      logic        mis;
      logic        hold;
      logic [31:0] base;
      mis  = is_misaligned(e.width, e.alu_y[1:0]);
      base = e.base_src ? e.rs1 : e.pc;
      case (e.cond)
         jump_always:    hold = 1'b1;
         jump_lsb_set:   hold = e.alu_y[0];
         jump_lsb_clear: hold = !e.alu_y[0];
         default:        hold = 1'b0;
      endcase
      r.trap_taken   = !flush;
      r.trap_src     = cause_ins_misalign;
      r.target       = e.mtvec;
      r.branch_taken = 1'b0;
      if (pend) r.trap_src = cause_external_int;
      else if (e.ins_misalign) r.trap_src = cause_ins_misalign;
      else if (e.ins_illegal) r.trap_src = cause_ins_illegal;
      else if (e.ecall) r.trap_src = cause_ecall;
      else if (e.ebreak) r.trap_src = cause_breakpoint;
      else if (mis && e.read) r.trap_src = cause_load_misalign;
      else if (mis && e.write) r.trap_src = cause_store_misalign;
      else r.trap_taken = 1'b0;
      if (!r.trap_taken) begin
         r.trap_src = cause_ins_misalign;
         if (e.trap_return && !flush) begin
            r.target       = e.mepc;
            r.branch_taken = 1'b1;
         end else begin
            r.target       = (base + e.imm) & 32'hffff_fffe;
            r.branch_taken = hold && !flush;
         end
      end
      return r;
   endfunction

   function automatic logic [31:0] extract_load(input logic [31:0] word, input width_e w,
                                                input logic [1:0] off, input logic zext);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*off +: 8];
      h = word[16*off[1] +: 16];
      case (w)
         width_byte: return {{24{!zext && b[7]}}, b};
         width_half: return {{16{!zext && h[15]}}, h};
         default:    return word;
      endcase
   endfunction

   task automatic check_redirect(input redirect_t got, input redirect_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: redirect is %h, expected %h", $time, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_load(input load_t got, input load_t exp, input logic data_known);
      if (got.valid !== exp.valid || (data_known && got.data !== exp.data)) begin
         $display("Error at %0t ns: load is %h, expected %h", $time, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: dmem_addr is %h, expected %h", $time, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   // mid-cycle compare, then the models advance to the next cycle.
   always @(negedge clk) begin
      if (rst) begin
         pend_model     <= 1'b0;
         exp_load       <= '0;
         exp_data_known <= 1'b0;
      end else begin
         check_redirect(redirect, ref_redirect(ex, pend_model, pipe_flush));
         check_load(load, exp_load, exp_data_known);
         check_addr(dmem_addr, ex.alu_y);
         exp_load.valid <= ex.read;
         exp_load.data  <= extract_load(shadow[ex.alu_y[DMEM_AW+1:2]], ex.width,
                                        ex.alu_y[1:0], ex.zero_ext);
         exp_data_known <= ex.read && !is_misaligned(ex.width, ex.alu_y[1:0]);
         if (ex.write && !pipe_flush && !is_misaligned(ex.width, ex.alu_y[1:0])) begin
            for (int i = 0; i < 4; i++) begin
               if (ex.width == width_word) begin
                  shadow[ex.alu_y[DMEM_AW+1:2]][8*i +: 8] <= ex.rs2[8*i +: 8];
               end else if (ex.width == width_half && i[1] == ex.alu_y[1]) begin
                  shadow[ex.alu_y[DMEM_AW+1:2]][8*i +: 8] <= ex.rs2[8*(i%2) +: 8];
               end else if (ex.width == width_byte && i[1:0] == ex.alu_y[1:0]) begin
                  shadow[ex.alu_y[DMEM_AW+1:2]][8*i +: 8] <= ex.rs2[7:0];
               end
            end
         end
         if (pend_model && !pipe_flush) pend_model <= 1'b0;
         else if (external_int) pend_model <= 1'b1;
      end
   end

   function automatic ex_mb_t idle_ex();
      ex_mb_t e;
      e       = '0;
      e.mtvec = 32'h0000_0100;
      e.mepc  = 32'h0000_0200;
      e.width = width_word;
      e.cond  = jump_none;
      return e;
   endfunction

   function automatic ex_mb_t mem_op(input logic [31:0] addr, input width_e w,
                                     input logic wr, input logic [31:0] data,
                                     input logic zext);
      ex_mb_t e;
      e          = idle_ex();
      e.alu_y    = addr;
      e.width    = w;
      e.write    = wr;
      e.read     = !wr;
      e.rs2      = data;
      e.zero_ext = zext;
      return e;
   endfunction

   task automatic apply(input ex_mb_t e, input logic flush, input logic ext);
      @(posedge clk);
      #1;
      ex           = e;
      pipe_flush   = flush;
      external_int = ext;
   endtask

   initial begin
      ex_mb_t      e;
      width_e      w;
      logic [31:0] a;
      rst          = 1'b1;
      pipe_flush   = 1'b0;
      external_int = 1'b0;
      ex           = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < 8; i++) begin
         addr_pool[i] = $random(seed) & 32'h1ffc;
         apply(mem_op(addr_pool[i], width_word, 1'b1, $random(seed), 1'b0), 1'b0, 1'b0);
      end
      // aligned stores, then loads both ways.
      for (int i = 0; i < 24; i++) begin
         w = width_e'($unsigned($random(seed)) % 3);
         a = addr_pool[3'($random(seed))];
         if (w == width_byte) a[1:0] = 2'($random(seed));
         if (w == width_half) a[1] = 1'($random(seed));
         apply(mem_op(a, w, 1'b1, $random(seed), 1'b0), 1'b0, 1'b0);
         apply(mem_op(a, w, 1'b0, 32'h0, 1'b0), 1'b0, 1'b0);
         apply(mem_op(a, w, 1'b0, 32'h0, 1'b1), 1'b0, 1'b0);
      end
      // misaligned accesses trap.
      apply(mem_op(addr_pool[0] + 1, width_word, 1'b0, 32'h0, 1'b0), 1'b0, 1'b0);
      apply(mem_op(addr_pool[1] + 3, width_half, 1'b1, 32'hdead_beef, 1'b0), 1'b0, 1'b0);
      apply(mem_op(addr_pool[1] + 2, width_word, 1'b1, 32'hcafe_f00d, 1'b0), 1'b0, 1'b0);
      apply(mem_op(addr_pool[1], width_word, 1'b0, 32'h0, 1'b0), 1'b0, 1'b0);
      for (int c = 0; c < 4; c++) begin
         for (int s = 0; s < 4; s++) begin
            e          = idle_ex();
            e.cond     = jump_cond_e'(c);
            e.base_src = s[0];
            e.pc       = $random(seed);
            e.rs1      = $random(seed);
            e.imm      = $random(seed);
            e.alu_y    = $random(seed);
            e.alu_y[0] = s[1];
            apply(e, 1'b0, 1'b0);
         end
      end
      // trap priority and trap return.
      e = idle_ex();
      e.ins_illegal = 1'b1;
      e.ecall       = 1'b1;
      e.ebreak      = 1'b1;
      apply(e, 1'b0, 1'b0);
      e.ins_illegal = 1'b0;
      apply(e, 1'b0, 1'b0);
      e = mem_op(addr_pool[2] + 2, width_word, 1'b0, 32'h0, 1'b0);
      e.ebreak = 1'b1;
      apply(e, 1'b0, 1'b0);
      e = idle_ex();
      e.trap_return = 1'b1;
      e.cond        = jump_always;
      apply(e, 1'b0, 1'b0);
      e.ecall = 1'b1;
      apply(e, 1'b0, 1'b0);
      e.ins_misalign = 1'b1;
      apply(e, 1'b0, 1'b0);
      // interrupt held off by a flush.
      apply(idle_ex(), 1'b1, 1'b1);
      apply(idle_ex(), 1'b1, 1'b0);
      apply(idle_ex(), 1'b0, 1'b0);
      apply(idle_ex(), 1'b0, 1'b0);
      // flushed store and jump.
      e      = mem_op(addr_pool[3], width_word, 1'b1, 32'h1234_5678, 1'b0);
      e.cond = jump_always;
      apply(e, 1'b1, 1'b0);
      apply(mem_op(addr_pool[3], width_word, 1'b0, 32'h0, 1'b0), 1'b0, 1'b0);
      apply(idle_ex(), 1'b0, 1'b0);
      apply(idle_ex(), 1'b0, 1'b0);
      @(posedge clk);
      @(negedge clk);
      $display("Test OK");
      $finish;
   end

endmodule

/* dv/mem_branch_checker.sv */
`timescale 1ns/1ps

module mem_branch_checker
   import mb_stage_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input logic      pipe_flush,
   input redirect_t redirect,
   input load_t     load
);

   // one redirect kind at a time.
   a_one_kind : assert property (@(posedge clk) disable iff (rst)
      !(redirect.trap_taken && redirect.branch_taken))
      else $error("trap and branch taken together");

   a_flush_quiet : assert property (@(posedge clk) disable iff (rst)
      pipe_flush |-> !redirect.trap_taken && !redirect.branch_taken)
      else $error("redirect during a flush");

   // the load register clears in reset.
   a_reset_load : assert property (@(posedge clk) rst |=> !load.valid)
      else $error("load valid after reset");

endmodule

bind mem_branch mem_branch_checker chk0 (
   .clk        (clk),
   .rst        (rst),
   .pipe_flush (pipe_flush),
   .redirect   (redirect),
   .load       (load)
);

/* src/mem_branch.sv */
`timescale 1ns/1ps

module mem_branch
   import mb_stage_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        pipe_flush,
   input  logic        external_int,
   input  ex_mb_t      ex,
   output redirect_t   redirect,
   output logic [31:0] dmem_addr,
   output load_t       load
);

   mem_fault_t fault;
   branch_t    branch;

   mem_access u_mem_access (
      .clk        (clk),
      .rst        (rst),
      .pipe_flush (pipe_flush),
      .ex         (ex),
      .fault      (fault),
      .dmem_addr  (dmem_addr),
      .load       (load)
   );

   branch_resolve u_branch_resolve (
      .pipe_flush (pipe_flush),
      .ex         (ex),
      .branch     (branch)
   );

   trap_arbiter u_trap_arbiter (
      .clk          (clk),
      .rst          (rst),
      .pipe_flush   (pipe_flush),
      .external_int (external_int),
      .ex           (ex),
      .fault        (fault),
      .branch       (branch),
      .redirect     (redirect)
   );

endmodule

/* src/trap_arbiter.sv */
`timescale 1ns/1ps

module trap_arbiter
   import rv_isa_pkg::*;
   import mb_stage_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       pipe_flush,
   input  logic       external_int,
   input  ex_mb_t     ex,
   input  mem_fault_t fault,
   input  branch_t    branch,
   output redirect_t  redirect
);

   logic        int_pending;
   logic        int_taken;
   logic        trap_taken;
   trap_cause_e cause;

   assign int_taken = int_pending && !pipe_flush;

   // taking the interrupt wins over a new request.
   always_ff @(posedge clk) begin
      if (rst) begin
         int_pending <= 1'b0;
      end else if (int_taken) begin
         int_pending <= 1'b0;
      end else if (external_int) begin
         int_pending <= 1'b1;
      end
   end

   // fixed priority, nothing counts during a flush.
   always_comb begin
      trap_taken = !pipe_flush;
      cause      = cause_ins_misalign;
      if (int_pending) begin
         cause = cause_external_int;
      end else if (ex.ins_misalign) begin
         cause = cause_ins_misalign;
      end else if (ex.ins_illegal) begin
         cause = cause_ins_illegal;
      end else if (ex.ecall) begin
         cause = cause_ecall;
      end else if (ex.ebreak) begin
         cause = cause_breakpoint;
      end else if (fault.load_misalign) begin
         cause = cause_load_misalign;
      end else if (fault.store_misalign) begin
         cause = cause_store_misalign;
      end else begin
         trap_taken = 1'b0;
      end
   end

   always_comb begin
      redirect.trap_taken = trap_taken;
      redirect.trap_src   = trap_taken ? cause : cause_ins_misalign;
      if (trap_taken) begin
         redirect.target       = ex.mtvec;
         redirect.branch_taken = 1'b0;
      end else if (ex.trap_return && !pipe_flush) begin
         redirect.target       = ex.mepc;
         redirect.branch_taken = 1'b1;
      end else begin
         redirect.target       = branch.target;
         redirect.branch_taken = branch.taken;
      end
   end

endmodule

/* src/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve
   import rv_isa_pkg::*;
   import mb_stage_pkg::*;
(
   input  logic    pipe_flush,
   input  ex_mb_t  ex,
   output branch_t branch
);

   logic [31:0] base;
   logic [31:0] sum;
   logic        cond_hold;

   // base_src set means register-relative.
   assign base = ex.base_src ? ex.rs1 : ex.pc;
   assign sum  = base + ex.imm;

   always_comb begin
      case (ex.cond)
         jump_always:    cond_hold = 1'b1;
         jump_lsb_set:   cond_hold = ex.alu_y[0];
         jump_lsb_clear: cond_hold = !ex.alu_y[0];
         default:        cond_hold = 1'b0;
      endcase
   end

   assign branch.target = {sum[31:1], 1'b0};
   assign branch.taken  = cond_hold && !pipe_flush;

endmodule

/* mem_access/mem_access.sv */
`timescale 1ns/1ps

module mem_access
   import rv_isa_pkg::*;
   import mb_stage_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       pipe_flush,
   input  ex_mb_t     ex,
   output mem_fault_t fault,
   output logic [31:0] dmem_addr,
   output load_t      load
);

   logic [1:0]  off;
   logic        misalign;
   logic        store_en;
   logic [3:0]  lanes;
   logic [3:0]  writeb;
   logic [31:0] wdata;
   logic [31:0] rdata;

   width_e      width_q;
   logic [1:0]  off_q;
   logic        zero_ext_q;
   logic        read_q;
   logic [7:0]  lane_byte;
   logic [15:0] lane_half;
   logic [31:0] load_data;

   assign dmem_addr = ex.alu_y;
   assign off       = ex.alu_y[1:0];

   assign misalign = (ex.width == width_half && off == 2'b11)
                  || (ex.width == width_word && off != 2'b00);

   assign fault.load_misalign  = misalign && ex.read;
   assign fault.store_misalign = misalign && ex.write;

   assign store_en = ex.write && !pipe_flush && !misalign;

   // replicate the data, the enables pick the lanes.
   always_comb begin
      wdata = ex.rs2;
      lanes = 4'b1111;
      case (ex.width)
         width_byte: begin
            wdata = {4{ex.rs2[7:0]}};
            lanes = 4'b0001 << off;
         end
         width_half: begin
            wdata = {2{ex.rs2[15:0]}};
            lanes = off[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
         end
      endcase
   end

   assign writeb = store_en ? lanes : 4'b0000;

   dmem_ram u_dmem_ram (
      .clk    (clk),
      .read   (ex.read),
      .writeb (writeb),
      .addr   (ex.alu_y[DMEM_AW+1:2]),
      .wdata  (wdata),
      .rdata  (rdata)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         read_q <= 1'b0;
      end else begin
         read_q <= ex.read;
      end
   end

   always_ff @(posedge clk) begin
      width_q    <= ex.width;
      off_q      <= off;
      zero_ext_q <= ex.zero_ext;
   end

   // half select uses offset bit 1 only.
   assign lane_byte = rdata[8*off_q +: 8];
   assign lane_half = rdata[16*off_q[1] +: 16];

   always_comb begin
      case (width_q)
         width_byte: load_data = {{24{!zero_ext_q && lane_byte[7]}}, lane_byte};
         width_half: load_data = {{16{!zero_ext_q && lane_half[15]}}, lane_half};
         default:    load_data = rdata;
      endcase
   end

   assign load.data  = load_data;
   assign load.valid = read_q;

endmodule

/* mem_access/dmem_ram.sv */
`timescale 1ns/1ps

module dmem_ram
   import mb_stage_pkg::*;
(
   input  logic               clk,
   input  logic               read,
   input  logic [3:0]         writeb,
   input  logic [DMEM_AW-1:0] addr,
   input  logic [31:0]        wdata,
   output logic [31:0]        rdata
);

   logic [31:0] mem [DMEM_WORDS];

   // read returns the old word on a same-cycle write.
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (writeb[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
      if (read) begin
         rdata <= mem[addr];
      end
   end

endmodule

/* common/mb_stage_pkg.sv */
package mb_stage_pkg;
   import rv_isa_pkg::*;

   localparam int DMEM_WORDS = 2048;
   localparam int DMEM_AW    = 11;

   // execute results for one instruction.
   typedef struct packed {
      logic            ins_misalign;
      logic            ins_illegal;
      logic            ecall;
      logic            ebreak;
      logic            trap_return;
      logic [XLEN-1:0] mtvec;
      logic [XLEN-1:0] mepc;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] imm;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
      logic [XLEN-1:0] alu_y;
      width_e          width;
      logic            zero_ext;
      logic            read;
      logic            write;
      logic            base_src;
      jump_cond_e      cond;
   } ex_mb_t;

   // redirect record to fetch.
   typedef struct packed {
      logic [XLEN-1:0] target;
      logic            branch_taken;
      logic            trap_taken;
      trap_cause_e     trap_src;
   } redirect_t;

   // write-back load result, one cycle after the read.
   typedef struct packed {
      logic [XLEN-1:0] data;
      logic            valid;
   } load_t;

   typedef struct packed {
      logic load_misalign;
      logic store_misalign;
   } mem_fault_t;

   typedef struct packed {
      logic [XLEN-1:0] target;
      logic            taken;
   } branch_t;

endpackage

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

   localparam int XLEN = 32;

   // load and store access size.
   typedef enum logic [1:0] {
      width_byte = 2'd0,
      width_half = 2'd1,
      width_word = 2'd2
   } width_e;

   // jump condition, tested against alu result bit 0.
   typedef enum logic [1:0] {
      jump_none      = 2'd0,
      jump_always    = 2'd1,
      jump_lsb_set   = 2'd2,
      jump_lsb_clear = 2'd3
   } jump_cond_e;

   // mcause style codes, bit 4 marks an interrupt.
   typedef enum logic [4:0] {
      cause_ins_misalign   = 5'd0,
      cause_ins_illegal    = 5'd2,
      cause_breakpoint     = 5'd3,
      cause_load_misalign  = 5'd4,
      cause_store_misalign = 5'd6,
      cause_ecall          = 5'd11,
      cause_external_int   = 5'd27
   } trap_cause_e;

endpackage
